/* tl_macros.svh */
`ifndef TL_MACROS_SVH
`define TL_MACROS_SVH

// Data widths of the host port and of the memory device port, in bits.
`define TL_HOST_DW 64
`define TL_DEV_DW 32

// Byte address width and source identifier width.
`define TL_AW 12
`define TL_SW 4

// Log2 of the largest transfer in bytes, and the depth of the memory in words.
`define TL_MAX_SIZE 6
`define TL_MEM_WORDS 1024

// A channel opcodes.
`define TL_OP_PUT_FULL 0
`define TL_OP_GET 4

// D channel opcodes.
`define TL_OP_ACK 0
`define TL_OP_ACK_DATA 1

`endif

/* tl_pkg.sv */
`default_nettype none

`include "tl_macros.svh"

package tl_pkg;

  // Byte offset bits inside one device beat.
  localparam int unsigned TL_DEV_OFF = $clog2(`TL_DEV_DW / 8);

  // Host side A channel, one 64-bit beat.
  typedef struct packed {
    logic [2:0]                 opcode;
    logic [2:0]                 size;
    logic [`TL_SW-1:0]          source;
    logic [`TL_AW-1:0]          address;
    logic [`TL_HOST_DW/8-1:0]   mask;
    logic [`TL_HOST_DW-1:0]     data;
  } tl_h2d_host_a_t;

  // Device side A channel, same fields at the narrow width.
  typedef struct packed {
    logic [2:0]                 opcode;
    logic [2:0]                 size;
    logic [`TL_SW-1:0]          source;
    logic [`TL_AW-1:0]          address;
    logic [`TL_DEV_DW/8-1:0]    mask;
    logic [`TL_DEV_DW-1:0]      data;
  } tl_h2d_dev_a_t;

  // Host side D channel.
  typedef struct packed {
    logic [2:0]                 opcode;
    logic [2:0]                 size;
    logic [`TL_SW-1:0]          source;
    logic [`TL_HOST_DW-1:0]     data;
  } tl_d2h_host_d_t;

  // Device side D channel.
  typedef struct packed {
    logic [2:0]                 opcode;
    logic [2:0]                 size;
    logic [`TL_SW-1:0]          source;
    logic [`TL_DEV_DW-1:0]      data;
  } tl_d2h_dev_d_t;

  // Device beat count of a burst, enough for 16 beats of 4 bytes.
  typedef logic [3:0] tl_burst_len_t;

  // Number of device beats minus one that carry a payload of 2^size bytes.
  // Anything at or below the device width fits in a single beat.
  function automatic tl_burst_len_t tl_dev_len_m1(logic [2:0] size);
    tl_burst_len_t len;
    len = '0;
    if (size > TL_DEV_OFF) begin
      len = tl_burst_len_t'((1 << (size - TL_DEV_OFF)) - 1);
    end
    return len;
  endfunction

endpackage

`default_nettype wire

/* tl_regslice.sv */
`timescale 1ns/1ps
`default_nettype none

// Two-entry register slice. Both the output side and the input ready come
// straight from flops, so no combinational path crosses the slice.
module tl_regslice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     out_valid_q, out_valid_d;
  logic     skid_valid_q, skid_valid_d;
  logic     ready_q;
  payload_t out_data_q, out_data_d;
  payload_t skid_data_q, skid_data_d;
  logic     in_fire;

  // Ready tracks an empty skid entry, so an accepted item always has a home.
  assign in_fire = in_valid_i && ready_q;

  always_comb begin
    out_valid_d  = out_valid_q;
    out_data_d   = out_data_q;
    skid_valid_d = skid_valid_q;
    skid_data_d  = skid_data_q;
    if (!out_valid_q || out_ready_i) begin
      // The output entry is free this cycle. The older skid item goes first.
      if (skid_valid_q) begin
        out_valid_d  = 1'b1;
        out_data_d   = skid_data_q;
        skid_valid_d = 1'b0;
      end else begin
        out_valid_d = in_fire;
        if (in_fire) begin
          out_data_d = in_data_i;
        end
      end
    end else if (in_fire) begin
      // Output is stalled, so park the new item in the skid entry.
      skid_valid_d = 1'b1;
      skid_data_d  = in_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b0;
    end else begin
      out_valid_q  <= out_valid_d;
      skid_valid_q <= skid_valid_d;
      ready_q      <= !skid_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    out_data_q  <= out_data_d;
    skid_data_q <= skid_data_d;
  end

  assign in_ready_o  = ready_q;
  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

endmodule

`default_nettype wire

/* tl_burst_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tl_macros.svh"

// Passive monitor of the device side A and D channels. It counts beats
// within each burst and reports where the current beat sits.
module tl_burst_tracker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  a_valid_i,
  input  logic                  a_ready_i,
  input  tl_pkg::tl_h2d_dev_a_t a_i,
  input  logic                  d_valid_i,
  input  logic                  d_ready_i,
  input  tl_pkg::tl_d2h_dev_d_t d_i,
  output tl_pkg::tl_burst_len_t a_idx_o,
  output tl_pkg::tl_burst_len_t a_left_o,
  output tl_pkg::tl_burst_len_t d_len_o,
  output tl_pkg::tl_burst_len_t d_idx_o,
  output tl_pkg::tl_burst_len_t d_left_o
);

  import tl_pkg::*;

  tl_burst_len_t a_len;
  tl_burst_len_t d_len;
  tl_burst_len_t a_cnt_q;
  tl_burst_len_t d_cnt_q;
  logic          a_fire;
  logic          d_fire;

  assign a_fire = a_valid_i && a_ready_i;
  assign d_fire = d_valid_i && d_ready_i;

  // A Get request carries no data and is always one beat, whatever its size.
  assign a_len = (a_i.opcode == 3'(`TL_OP_GET)) ? '0 : tl_dev_len_m1(a_i.size);

  // Likewise a plain AccessAck is a single beat.
  assign d_len = (d_i.opcode == 3'(`TL_OP_ACK)) ? '0 : tl_dev_len_m1(d_i.size);

  // The payload is stable during a burst, so the length read from the current
  // beat is the length of the whole burst.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_cnt_q <= '0;
      d_cnt_q <= '0;
    end else begin
      if (a_fire) begin
        a_cnt_q <= (a_cnt_q == a_len) ? '0 : a_cnt_q + 1'b1;
      end
      if (d_fire) begin
        d_cnt_q <= (d_cnt_q == d_len) ? '0 : d_cnt_q + 1'b1;
      end
    end
  end

  assign a_idx_o  = a_cnt_q;
  assign a_left_o = a_len - a_cnt_q;
  assign d_len_o  = d_len;
  assign d_idx_o  = d_cnt_q;
  assign d_left_o = d_len - d_cnt_q;

endmodule

`default_nettype wire

/* tl_data_downsizer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tl_macros.svh"

// Width adapter from the 64-bit host port down to the 32-bit device port.
module tl_data_downsizer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   host_a_valid_i,
  output logic                   host_a_ready_o,
  input  tl_pkg::tl_h2d_host_a_t host_a_i,
  output logic                   host_d_valid_o,
  input  logic                   host_d_ready_i,
  output tl_pkg::tl_d2h_host_d_t host_d_o,
  output logic                   dev_a_valid_o,
  input  logic                   dev_a_ready_i,
  output tl_pkg::tl_h2d_dev_a_t  dev_a_o,
  input  logic                   dev_d_valid_i,
  output logic                   dev_d_ready_o,
  input  tl_pkg::tl_d2h_dev_d_t  dev_d_i
);

  import tl_pkg::*;

  // Device sub-beats per host beat and the bits to index them.
  localparam int unsigned SUB_N = `TL_HOST_DW / `TL_DEV_DW;
  localparam int unsigned SUB_W = $clog2(SUB_N);

  logic           ha_valid, ha_ready;
  tl_h2d_host_a_t ha;
  logic           hd_valid, hd_ready;
  tl_d2h_host_d_t hd;

  tl_burst_len_t a_idx, a_left;
  tl_burst_len_t d_len, d_idx, d_left;

  // The A path reads the host beat before consuming it, which needs a stable payload.
  tl_regslice #(
    .payload_t (tl_h2d_host_a_t)
  ) a_slice (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (host_a_valid_i),
    .in_ready_o  (host_a_ready_o),
    .in_data_i   (host_a_i),
    .out_valid_o (ha_valid),
    .out_ready_i (ha_ready),
    .out_data_o  (ha)
  );

  tl_burst_tracker dev_tracker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_valid_i (dev_a_valid_o),
    .a_ready_i (dev_a_ready_i),
    .a_i       (dev_a_o),
    .d_valid_i (dev_d_valid_i),
    .d_ready_i (dev_d_ready_o),
    .d_i       (dev_d_i),
    .a_idx_o   (a_idx),
    .a_left_o  (a_left),
    .d_len_o   (d_len),
    .d_idx_o   (d_idx),
    .d_left_o  (d_left)
  );

  ////////////////////////////////////////////////////////////////////////////
  // A channel split
  ////////////////////////////////////////////////////////////////////////////

  logic [SUB_N-1:0][`TL_DEV_DW-1:0]   a_data_split;
  logic [SUB_N-1:0][`TL_DEV_DW/8-1:0] a_mask_split;
  logic [SUB_W-1:0]                   a_lane;

  assign a_data_split = ha.data;
  assign a_mask_split = ha.mask;

  // Addresses are naturally aligned, so the start lane and the sub-beat index
  // never overlap and an OR does the job of an add.
  assign a_lane = ha.address[TL_DEV_OFF +: SUB_W] | a_idx[SUB_W-1:0];

  // The host beat is only consumed together with its last sub-beat.
  assign ha_ready = dev_a_ready_i && ha_valid && (a_left[SUB_W-1:0] == '0);

  assign dev_a_valid_o   = ha_valid;
  assign dev_a_o.opcode  = ha.opcode;
  assign dev_a_o.size    = ha.size;
  assign dev_a_o.source  = ha.source;
  assign dev_a_o.address = ha.address;
  assign dev_a_o.mask    = a_mask_split[a_lane];
  assign dev_a_o.data    = a_data_split[a_lane];

  ////////////////////////////////////////////////////////////////////////////
  // D channel gather
  ////////////////////////////////////////////////////////////////////////////

  // The top lane always arrives last, so only the lower lanes are stored.
  logic [SUB_N-2:0][`TL_DEV_DW-1:0] d_data_q, d_data_d;
  logic                             d_last;
  logic                             dev_d_fire;

  assign d_last     = (d_left[SUB_W-1:0] == '0);
  assign dev_d_fire = dev_d_valid_i && dev_d_ready_o;

  always_comb begin
    d_data_d = d_data_q;
    // Masking the lane with the burst length repeats a short response across
    // every lane. For a full burst the mask is all ones and each lane is unique.
    for (int i = 0; i < SUB_N - 1; i++) begin
      if ((SUB_W'(i) & d_len[SUB_W-1:0]) == d_idx[SUB_W-1:0]) begin
        d_data_d[i] = dev_d_i.data;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dev_d_fire) begin
      d_data_q <= d_last ? '0 : d_data_d;
    end
  end

  // Earlier sub-beats are soaked up, the last one waits for the host side.
  assign dev_d_ready_o = (dev_d_valid_i && d_last) ? hd_ready : 1'b1;
  assign hd_valid      = dev_d_valid_i && d_last;
  assign hd.opcode     = dev_d_i.opcode;
  assign hd.size       = dev_d_i.size;
  assign hd.source     = dev_d_i.source;
  assign hd.data       = {dev_d_i.data, d_data_d};

  tl_regslice #(
    .payload_t (tl_d2h_host_d_t)
  ) d_slice (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (hd_valid),
    .in_ready_o  (hd_ready),
    .in_data_i   (hd),
    .out_valid_o (host_d_valid_o),
    .out_ready_i (host_d_ready_i),
    .out_data_o  (host_d_o)
  );

endmodule

`default_nettype wire

/* tl_mem_device.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tl_macros.svh"

// Word-wide memory that answers Get and PutFullData bursts one at a time.
module tl_mem_device (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  a_valid_i,
  output logic                  a_ready_o,
  input  tl_pkg::tl_h2d_dev_a_t a_i,
  output logic                  d_valid_o,
  input  logic                  d_ready_i,
  output tl_pkg::tl_d2h_dev_d_t d_o
);

  import tl_pkg::*;

  localparam int unsigned WORD_W = $clog2(`TL_MEM_WORDS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_RESP
  } state_e;

  state_e                state_q;
  logic [`TL_DEV_DW-1:0] mem_q [`TL_MEM_WORDS];
  logic [WORD_W-1:0]     ptr_q;
  logic [WORD_W-1:0]     wr_ptr;
  tl_burst_len_t         left_q;
  logic                  is_get_q;
  logic [2:0]            size_q;
  logic [`TL_SW-1:0]     source_q;
  logic                  a_fire;
  logic                  d_fire;

  // No new request is taken while a response is pending.
  assign a_ready_o = (state_q == ST_IDLE) || (state_q == ST_WRITE);
  assign d_valid_o = (state_q == ST_RESP);
  assign a_fire    = a_valid_i && a_ready_o;
  assign d_fire    = d_valid_o && d_ready_i;

  // The first write beat takes its word from the address, later ones follow the pointer.
  assign wr_ptr = (state_q == ST_IDLE) ? a_i.address[TL_DEV_OFF +: WORD_W] : ptr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      ptr_q    <= '0;
      left_q   <= '0;
      is_get_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (a_fire) begin
            // For a Get this counts response beats, for a Put the beats still to come.
            left_q   <= tl_dev_len_m1(a_i.size);
            is_get_q <= (a_i.opcode == 3'(`TL_OP_GET));
            if (a_i.opcode == 3'(`TL_OP_GET)) begin
              ptr_q   <= wr_ptr;
              state_q <= ST_RESP;
            end else begin
              ptr_q   <= wr_ptr + 1'b1;
              state_q <= (tl_dev_len_m1(a_i.size) == '0) ? ST_RESP : ST_WRITE;
            end
          end
        end
        ST_WRITE: begin
          if (a_fire) begin
            ptr_q  <= ptr_q + 1'b1;
            left_q <= left_q - 1'b1;
            if (left_q == tl_burst_len_t'(1)) begin
              state_q <= ST_RESP;
            end
          end
        end
        ST_RESP: begin
          if (d_fire) begin
            if (left_q == '0) begin
              state_q <= ST_IDLE;
            end else begin
              // The pointer wraps at the top of the array.
              left_q <= left_q - 1'b1;
              ptr_q  <= ptr_q + 1'b1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Storage and the request fields echoed in the response.
  always_ff @(posedge clk_i) begin
    if (a_fire && (a_i.opcode == 3'(`TL_OP_PUT_FULL))) begin
      for (int b = 0; b < `TL_DEV_DW / 8; b++) begin
        if (a_i.mask[b]) begin
          mem_q[wr_ptr][8*b +: 8] <= a_i.data[8*b +: 8];
        end
      end
    end
    if (a_fire && (state_q == ST_IDLE)) begin
      size_q   <= a_i.size;
      source_q <= a_i.source;
    end
  end

  assign d_o.opcode = is_get_q ? 3'(`TL_OP_ACK_DATA) : 3'(`TL_OP_ACK);
  assign d_o.size   = size_q;
  assign d_o.source = source_q;
  assign d_o.data   = mem_q[ptr_q];

endmodule

`default_nettype wire

/* tl_downsize_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Host port through the width adapter into the 32-bit memory.
module tl_downsize_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   host_a_valid_i,
  output logic                   host_a_ready_o,
  input  tl_pkg::tl_h2d_host_a_t host_a_i,
  output logic                   host_d_valid_o,
  input  logic                   host_d_ready_i,
  output tl_pkg::tl_d2h_host_d_t host_d_o
);

  import tl_pkg::*;

  // Device side link between the adapter and the memory.
  logic          dev_a_valid, dev_a_ready;
  tl_h2d_dev_a_t dev_a;
  logic          dev_d_valid, dev_d_ready;
  tl_d2h_dev_d_t dev_d;

  tl_data_downsizer downsizer0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .host_a_valid_i (host_a_valid_i),
    .host_a_ready_o (host_a_ready_o),
    .host_a_i       (host_a_i),
    .host_d_valid_o (host_d_valid_o),
    .host_d_ready_i (host_d_ready_i),
    .host_d_o       (host_d_o),
    .dev_a_valid_o  (dev_a_valid),
    .dev_a_ready_i  (dev_a_ready),
    .dev_a_o        (dev_a),
    .dev_d_valid_i  (dev_d_valid),
    .dev_d_ready_o  (dev_d_ready),
    .dev_d_i        (dev_d)
  );

  tl_mem_device mem0 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_valid_i (dev_a_valid),
    .a_ready_o (dev_a_ready),
    .a_i       (dev_a),
    .d_valid_o (dev_d_valid),
    .d_ready_i (dev_d_ready),
    .d_o       (dev_d)
  );

endmodule

`default_nettype wire

/* tb_tl_downsize_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

// Handshake rules on the host side of the top level.
module tb_tl_downsize_assertions (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   host_a_ready_i,
  input logic                   host_d_valid_i,
  input logic                   host_d_ready_i,
  input tl_pkg::tl_d2h_host_d_t host_d_i
);

  // A stalled response beat stays offered until it transfers.
  d_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_d_valid_i && !host_d_ready_i |=> host_d_valid_i)
    else $error("Host D valid dropped before its transfer.");

  // Its payload does not move while it waits.
  d_data_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_d_valid_i && !host_d_ready_i |=> $stable(host_d_i))
    else $error("Host D payload changed while stalled.");

  // Both slices come out of reset empty and closed.
  d_quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !host_d_valid_i)
    else $error("Host D valid is high during reset.");

  a_closed_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !host_a_ready_i)
    else $error("Host A ready is high during reset.");

endmodule

bind tl_downsize_top tb_tl_downsize_assertions host_checks0 (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .host_a_ready_i (host_a_ready_o),
  .host_d_valid_i (host_d_valid_o),
  .host_d_ready_i (host_d_ready_i),
  .host_d_i       (host_d_o)
);

`default_nettype wire

/* tb_tl_downsize.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tl_macros.svh"

// Testbench for the host port of the downsized memory subsystem.
module tb_tl_downsize;

  import tl_pkg::*;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned N_REQ      = 400;
  localparam int unsigned REQ_CYCLES = 64;
  // Random traffic stays inside this many bytes at the bottom of the memory.
  localparam int unsigned ADDR_RANGE = 256;
  localparam int unsigned PRELOAD_N  = ADDR_RANGE / 64;

  logic           clk_i;
  logic           rst_ni;
  logic           host_a_valid_i;
  logic           host_a_ready_o;
  tl_h2d_host_a_t host_a_i;
  logic           host_d_valid_o;
  logic           host_d_ready_i;
  tl_d2h_host_d_t host_d_o;

  logic [31:0]            rand_state;
  logic [7:0]             ref_mem [ADDR_RANGE];
  logic [`TL_HOST_DW-1:0] put_data [8];
  int unsigned            a_accepted;

  tl_downsize_top dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .host_a_valid_i (host_a_valid_i),
    .host_a_ready_o (host_a_ready_o),
    .host_a_i       (host_a_i),
    .host_d_valid_o (host_d_valid_o),
    .host_d_ready_i (host_d_ready_i),
    .host_d_o       (host_d_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Upper bound on the run with a generous number of cycles for every request.
  initial begin
    #(N_REQ * REQ_CYCLES * CLK_PERIOD);
    $display("Timeout: the requests did not complete within the allowed time.");
    $display("*** TEST FAILED ***");
    $fatal(1, "Watchdog expired.");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Linear congruential generator that supplies every random value.
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Byte lanes of a host beat that a request of this size and address covers.
  function automatic logic [7:0] lane_mask(logic [2:0] size, logic [`TL_AW-1:0] addr);
    logic [7:0] m;
    if (size >= 3'd3) begin
      m = 8'hFF;
    end else begin
      m = 8'(((1 << (1 << size)) - 1) << addr[2:0]);
    end
    return m;
  endfunction

  // Number of host beats in a data burst. Anything up to 8 bytes is one beat.
  function automatic int unsigned host_beats(logic [2:0] size);
    return (size >= 3'd3) ? (32'd1 << (size - 3'd3)) : 32'd1;
  endfunction

  // Host beat k of a Get, built from the byte model. Short reads come back as
  // the addressed 32-bit word repeated in both halves.
  function automatic logic [63:0] expected_beat(logic [2:0] size, logic [`TL_AW-1:0] addr,
                                                int unsigned k);
    logic [63:0] v;
    int unsigned base;
    v = '0;
    if (size >= 3'd3) begin
      base = 32'(addr) + 8 * k;
      for (int i = 0; i < 8; i++) begin
        v[8 * i +: 8] = ref_mem[8'(base + i)];
      end
    end else begin
      base = 32'(addr) & 32'hFFFF_FFFC;
      for (int i = 0; i < 4; i++) begin
        v[8 * i +: 8]      = ref_mem[8'(base + i)];
        v[32 + 8 * i +: 8] = ref_mem[8'(base + i)];
      end
    end
    return v;
  endfunction

  task automatic stop_on_error(string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      stop_on_error($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Mirror a completed Put into the byte model.
  task automatic apply_put(logic [2:0] size, logic [`TL_AW-1:0] addr, int unsigned beats);
    logic [7:0] m;
    int unsigned base;
    m    = lane_mask(size, addr);
    base = 32'(addr) & 32'hFFFF_FFF8;
    for (int unsigned k = 0; k < beats; k++) begin
      for (int i = 0; i < 8; i++) begin
        if (m[i]) begin
          ref_mem[8'(base + 8 * k + i)] = put_data[k][8 * i +: 8];
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Channel drivers
  ////////////////////////////////////////////////////////////////////////////

  // Drives the A beats of one request. A beat is counted as accepted once the
  // rising edge that transfers it has passed.
  task automatic send_request(logic is_get, logic [2:0] size, logic [`TL_SW-1:0] source,
                              logic [`TL_AW-1:0] addr, int unsigned beats);
    tl_h2d_host_a_t beat;
    for (int unsigned k = 0; k < beats; k++) begin
      beat.opcode  = is_get ? 3'(`TL_OP_GET) : 3'(`TL_OP_PUT_FULL);
      beat.size    = size;
      beat.source  = source;
      beat.address = addr;
      beat.mask    = lane_mask(size, addr);
      beat.data    = is_get ? '0 : put_data[k];
      @(negedge clk_i);
      host_a_valid_i = 1'b1;
      host_a_i       = beat;
      while (!host_a_ready_o) begin
        @(negedge clk_i);
      end
      @(posedge clk_i);
      a_accepted++;
    end
    @(negedge clk_i);
    host_a_valid_i = 1'b0;
  endtask

  // Takes the response beats under random back-pressure and checks each one.
  task automatic collect_response(logic is_get, logic [2:0] size, logic [`TL_SW-1:0] source,
                                  logic [`TL_AW-1:0] addr, int unsigned a_beats);
    int unsigned beats;
    int unsigned got_n;
    logic [31:0] r;
    beats = is_get ? host_beats(size) : 32'd1;
    got_n = 0;
    while (got_n < beats) begin
      @(negedge clk_i);
      r = next_rand();
      // Ready three times out of four.
      host_d_ready_i = (r[31:30] != 2'b00);
      if (host_d_valid_o && host_d_ready_i) begin
        check_value("host_d_o.opcode", 64'(host_d_o.opcode),
                    is_get ? 64'(`TL_OP_ACK_DATA) : 64'(`TL_OP_ACK));
        check_value("host_d_o.size", 64'(host_d_o.size), 64'(size));
        check_value("host_d_o.source", 64'(host_d_o.source), 64'(source));
        if (is_get) begin
          check_value("host_d_o.data", host_d_o.data, expected_beat(size, addr, got_n));
        end else begin
          assert (a_accepted == a_beats) else begin
            stop_on_error("An AccessAck arrived before every beat of its Put was accepted.");
          end
        end
        got_n++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]       r;
    logic              is_get;
    logic [2:0]        size;
    logic [`TL_SW-1:0] source;
    logic [`TL_AW-1:0] addr;
    int unsigned       a_beats;

    rst_ni         = 1'b0;
    host_a_valid_i = 1'b0;
    host_a_i       = '0;
    host_d_ready_i = 1'b0;
    rand_state     = 32'h8430_b978;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // The first requests fill the whole test range with 64-byte Puts, so
    // every later read has known contents.
    for (int n = 0; n < N_REQ; n++) begin
      r = next_rand();
      if (n < PRELOAD_N) begin
        is_get = 1'b0;
        size   = 3'd6;
        addr   = `TL_AW'(64 * n);
      end else begin
        is_get = r[31];
        size   = 3'(r[27:24] % 7);
        addr   = `TL_AW'(r[15:8]) & ~((`TL_AW'(1) << size) - `TL_AW'(1));
      end
      source  = r[7:4];
      a_beats = is_get ? 32'd1 : host_beats(size);
      for (int unsigned k = 0; k < a_beats; k++) begin
        put_data[k] = {next_rand(), next_rand()};
      end

      // Nothing may be left over from the previous response.
      @(negedge clk_i);
      host_d_ready_i = 1'b0;
      assert (!host_d_valid_o) else begin
        stop_on_error("A host D beat appeared with no request outstanding.");
      end
      a_accepted = 0;
      fork
        send_request(is_get, size, source, addr, a_beats);
        collect_response(is_get, size, source, addr, a_beats);
      join
      if (!is_get) begin
        apply_put(size, addr, a_beats);
      end
    end

    @(negedge clk_i);
    host_d_ready_i = 1'b1;
    repeat (8) begin
      @(negedge clk_i);
      assert (!host_d_valid_o) else begin
        stop_on_error("An extra host D beat appeared after the last response.");
      end
    end
    $display("Completed %0d requests.", N_REQ);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
tl_pkg.sv
tl_regslice.sv
tl_burst_tracker.sv
tl_data_downsizer.sv
tl_mem_device.sv
tl_downsize_top.sv
tb_tl_downsize_assertions.sv
tb_tl_downsize.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass banner.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_tl_downsize -o sim_tl_downsize
out=$(./obj_dir/sim_tl_downsize 2>&1) || true
echo "$out"
if echo "$out" | grep -q -F '*** TEST PASSED ***'; then
  exit 0
else
  exit 1
fi
